// ==== logic/exec_pkg.sv ====
/* Shared definitions for the integer execute cluster
   Data and ROB tag widths, operation and branch condition encodings */
package exec_pkg;

	localparam int XLEN      = 32;
	localparam int ROB_TAG_W = 4;
	localparam int SHAMT_W   = $clog2(XLEN); // Shift count field of rs2

	// Operation codes for both functional units
	// Bit 2 set means the adder subtracts (SUB, SLT, SLTU)
	// Bit 3 set marks a shift unit operation
	typedef enum logic [3:0] {
		OP_ADD  = 4'b0000,
		OP_XOR  = 4'b0001,
		OP_OR   = 4'b0010,
		OP_AND  = 4'b0011,
		OP_SUB  = 4'b0100,
		OP_SLT  = 4'b0101,
		OP_SLTU = 4'b0110,
		OP_SLL  = 4'b1000,
		OP_SRL  = 4'b1001,
		OP_SRA  = 4'b1010
	} alu_op_e;

	// Conditional branch types, resolved by the add unit
	typedef enum logic [2:0] {
		BR_NONE = 3'd0,
		BR_BEQ  = 3'd1,
		BR_BNE  = 3'd2,
		BR_BLT  = 3'd3,
		BR_BGE  = 3'd4,
		BR_BLTU = 3'd5,
		BR_BGEU = 3'd6
	} branch_e;

endpackage

// ==== logic/ripple_adder.sv ====
/* Ripple carry adder/subtractor
   Produces zero, negative, overflow and carry flags for compares and branches */
`timescale 1ns/1ns

module ripple_adder import exec_pkg::*; (
	input  logic [XLEN-1:0] a,
	input  logic [XLEN-1:0] b,
	input  logic            sub,
	output logic [XLEN-1:0] sum,
	output logic            zero,
	output logic            negative,
	output logic            overflow,
	output logic            carry
);

	logic [XLEN:0]   c; // Carry chain
	logic [XLEN-1:0] b_eff;

	// Two's complement subtract: invert b, carry in of one
	assign b_eff = sub ? ~b : b;
	assign c[0]  = sub;

	for (genvar i = 0; i < XLEN; i++) begin : g_bit
		logic p; // Propagate

		assign p        = a[i] ^ b_eff[i];
		assign sum[i]   = p ^ c[i];
		assign c[i + 1] = (a[i] & b_eff[i]) | (c[i] & p);
	end

	assign carry    = c[XLEN]; // No borrow when subtracting
	assign overflow = c[XLEN] ^ c[XLEN - 1];
	assign negative = sum[XLEN - 1];
	assign zero     = ~|sum;

endmodule

// ==== logic/add_unit.sv ====
/* Add/sub/compare/logic functional unit
   Resolves conditional branches from the adder flags and holds its
   result packet until the CDB arbiter takes it */
`timescale 1ns/1ns

module add_unit import exec_pkg::*; (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 valid_in,
	output logic                 ready,
	input  alu_op_e              alu_op,
	input  branch_e              branch_type,
	input  logic [XLEN-1:0]      rs1,
	input  logic [XLEN-1:0]      rs2,
	input  logic [ROB_TAG_W-1:0] rob_tag,
	input  logic                 load,
	output logic                 done,
	input  logic                 yumi,
	output logic [XLEN-1:0]      result,
	output logic [ROB_TAG_W-1:0] tag,
	output logic                 taken,
	output logic                 load_step1
);

	logic [XLEN-1:0] sum;
	logic [XLEN-1:0] alu_res;
	logic            zero;
	logic            negative;
	logic            overflow;
	logic            carry;
	logic            lt_s; // Signed less-than
	logic            br_cond;
	logic            accept;

	assign accept = valid_in & ready;
	assign ready  = ~done; // One instruction in flight

	ripple_adder adder0 (
		.a        (rs1),
		.b        (rs2),
		.sub      (alu_op[2]),
		.sum      (sum),
		.zero     (zero),
		.negative (negative),
		.overflow (overflow),
		.carry    (carry)
	);

	assign lt_s = negative ^ overflow;

	always_comb begin
		case (alu_op)
			OP_SLT:  alu_res = {{(XLEN - 1){1'b0}}, lt_s};
			OP_SLTU: alu_res = {{(XLEN - 1){1'b0}}, ~carry}; // Borrow out
			OP_XOR:  alu_res = rs1 ^ rs2;
			OP_OR:   alu_res = rs1 | rs2;
			OP_AND:  alu_res = rs1 & rs2;
			default: alu_res = sum; // ADD, SUB
		endcase
	end

	// Branch condition, meaningful only with OP_SUB
	always_comb begin
		case (branch_type)
			BR_BEQ:  br_cond = zero;
			BR_BNE:  br_cond = ~zero;
			BR_BLT:  br_cond = lt_s;
			BR_BGE:  br_cond = ~lt_s;
			BR_BLTU: br_cond = ~carry;
			BR_BGEU: br_cond = carry;
			default: br_cond = 1'b0;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			done <= 1'b0;
		end else if (accept) begin
			done <= 1'b1;
		end else if (yumi) begin
			done <= 1'b0; // Ready again next cycle
		end
	end

	// Result packet, held steady while done
	always_ff @(posedge clk) begin
		if (accept) begin
			result     <= alu_res;
			tag        <= rob_tag;
			taken      <= br_cond;
			load_step1 <= load;
		end
	end

	a_issue_ready: assert property (@(posedge clk) disable iff (!arst_n)
		valid_in |-> ready);

	// Shifts belong to the shift unit
	a_no_shift_op: assert property (@(posedge clk) disable iff (!arst_n)
		valid_in |-> !(alu_op inside {OP_SLL, OP_SRL, OP_SRA}));

endmodule

// ==== logic/shift_unit.sv ====
/* Iterative shift unit for SLL, SRL and SRA
   Shifts one bit per cycle, then holds the result until granted the CDB */
`timescale 1ns/1ns

module shift_unit import exec_pkg::*; (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 valid_in,
	output logic                 ready,
	input  alu_op_e              alu_op,
	input  logic [XLEN-1:0]      rs1,
	input  logic [XLEN-1:0]      rs2,
	input  logic [ROB_TAG_W-1:0] rob_tag,
	output logic                 done,
	input  logic                 yumi,
	output logic [XLEN-1:0]      result,
	output logic [ROB_TAG_W-1:0] tag
);

	typedef enum logic [1:0] {IDLE, SHIFT, HOLD} state_e;

	state_e             state;
	alu_op_e            op_q;
	logic [SHAMT_W-1:0] shamt;
	logic [SHAMT_W-1:0] count; // Bits left to shift
	logic [XLEN-1:0]    data;
	logic               accept;

	assign shamt  = rs2[SHAMT_W-1:0];
	assign accept = valid_in & ready;
	assign ready  = (state == IDLE);
	assign done   = (state == HOLD);
	assign result = data;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: if (valid_in) state <= (shamt == '0) ? HOLD : SHIFT;
				SHIFT: if (count == SHAMT_W'(1)) state <= HOLD; // Last bit this cycle
				HOLD: if (yumi) state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			data  <= rs1;
			count <= shamt;
			op_q  <= alu_op;
			tag   <= rob_tag;
		end else if (state == SHIFT) begin
			count <= count - 1'b1;
			case (op_q)
				OP_SLL:  data <= {data[XLEN-2:0], 1'b0};
				OP_SRA:  data <= {data[XLEN-1], data[XLEN-1:1]}; // Sign fill
				default: data <= {1'b0, data[XLEN-1:1]};
			endcase
		end
	end

	a_issue_ready: assert property (@(posedge clk) disable iff (!arst_n)
		valid_in |-> ready);

	a_shift_op: assert property (@(posedge clk) disable iff (!arst_n)
		valid_in |-> alu_op inside {OP_SLL, OP_SRL, OP_SRA});

endmodule

// ==== logic/cdb_arbiter.sv ====
/* Round-robin CDB arbiter for the add and shift units
   Grants one finished result per cycle and registers it onto the CDB */
`timescale 1ns/1ns

module cdb_arbiter import exec_pkg::*; (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 add_done,
	input  logic [XLEN-1:0]      add_result,
	input  logic [ROB_TAG_W-1:0] add_tag,
	input  logic                 add_taken,
	input  logic                 add_load_step1,
	output logic                 add_yumi,
	input  logic                 sh_done,
	input  logic [XLEN-1:0]      sh_result,
	input  logic [ROB_TAG_W-1:0] sh_tag,
	output logic                 sh_yumi,
	output logic                 cdb_valid,
	output logic [XLEN-1:0]      cdb_result,
	output logic [ROB_TAG_W-1:0] cdb_tag,
	output logic                 cdb_taken,
	output logic                 cdb_load_step1
);

	logic last_sh; // Shift unit won the last contested grant
	logic contested;

	assign contested = add_done & sh_done;
	assign add_yumi  = add_done & (~sh_done | last_sh);
	assign sh_yumi   = sh_done & (~add_done | ~last_sh);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			last_sh   <= 1'b0;
			cdb_valid <= 1'b0;
		end else begin
			cdb_valid <= add_yumi | sh_yumi; // One cycle per grant
			if (contested) last_sh <= sh_yumi;
		end
	end

	always_ff @(posedge clk) begin
		if (add_yumi) begin
			cdb_result     <= add_result;
			cdb_tag        <= add_tag;
			cdb_taken      <= add_taken;
			cdb_load_step1 <= add_load_step1;
		end else if (sh_yumi) begin
			cdb_result     <= sh_result;
			cdb_tag        <= sh_tag;
			cdb_taken      <= 1'b0; // Shifts never branch or load
			cdb_load_step1 <= 1'b0;
		end
	end

	// A unit left waiting keeps its packet until granted
	a_add_hold: assert property (@(posedge clk) disable iff (!arst_n)
		add_done && !add_yumi |=> add_done && $stable(add_result) && $stable(add_tag));
	a_sh_hold: assert property (@(posedge clk) disable iff (!arst_n)
		sh_done && !sh_yumi |=> sh_done && $stable(sh_result) && $stable(sh_tag));

endmodule

// ==== logic/exec_cluster.sv ====
/* Integer execute cluster top level
   Add unit and shift unit sharing one CDB through a round-robin arbiter */
`timescale 1ns/1ns

module exec_cluster import exec_pkg::*; (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 add_valid,
	output logic                 add_ready,
	input  alu_op_e              add_op,
	input  branch_e              add_branch,
	input  logic [XLEN-1:0]      add_rs1,
	input  logic [XLEN-1:0]      add_rs2,
	input  logic [ROB_TAG_W-1:0] add_tag,
	input  logic                 add_load,
	input  logic                 sh_valid,
	output logic                 sh_ready,
	input  alu_op_e              sh_op,
	input  logic [XLEN-1:0]      sh_rs1,
	input  logic [XLEN-1:0]      sh_rs2,
	input  logic [ROB_TAG_W-1:0] sh_tag,
	output logic                 cdb_valid,
	output logic [XLEN-1:0]      cdb_result,
	output logic [ROB_TAG_W-1:0] cdb_tag,
	output logic                 cdb_taken,
	output logic                 cdb_load_step1
);

	// Unit to arbiter result ports
	logic                 add_done;
	logic                 add_yumi;
	logic [XLEN-1:0]      add_res;
	logic [ROB_TAG_W-1:0] add_res_tag;
	logic                 add_taken;
	logic                 add_load_step1;
	logic                 sh_done;
	logic                 sh_yumi;
	logic [XLEN-1:0]      sh_res;
	logic [ROB_TAG_W-1:0] sh_res_tag;

	add_unit add0 (
		.clk         (clk),
		.arst_n      (arst_n),
		.valid_in    (add_valid),
		.ready       (add_ready),
		.alu_op      (add_op),
		.branch_type (add_branch),
		.rs1         (add_rs1),
		.rs2         (add_rs2),
		.rob_tag     (add_tag),
		.load        (add_load),
		.done        (add_done),
		.yumi        (add_yumi),
		.result      (add_res),
		.tag         (add_res_tag),
		.taken       (add_taken),
		.load_step1  (add_load_step1)
	);

	shift_unit sh0 (
		.clk      (clk),
		.arst_n   (arst_n),
		.valid_in (sh_valid),
		.ready    (sh_ready),
		.alu_op   (sh_op),
		.rs1      (sh_rs1),
		.rs2      (sh_rs2),
		.rob_tag  (sh_tag),
		.done     (sh_done),
		.yumi     (sh_yumi),
		.result   (sh_res),
		.tag      (sh_res_tag)
	);

	cdb_arbiter arb0 (
		.clk            (clk),
		.arst_n         (arst_n),
		.add_done       (add_done),
		.add_result     (add_res),
		.add_tag        (add_res_tag),
		.add_taken      (add_taken),
		.add_load_step1 (add_load_step1),
		.add_yumi       (add_yumi),
		.sh_done        (sh_done),
		.sh_result      (sh_res),
		.sh_tag         (sh_res_tag),
		.sh_yumi        (sh_yumi),
		.cdb_valid      (cdb_valid),
		.cdb_result     (cdb_result),
		.cdb_tag        (cdb_tag),
		.cdb_taken      (cdb_taken),
		.cdb_load_step1 (cdb_load_step1)
	);

endmodule

// ==== test/exec_cluster_tb.sv ====
/* Testbench for the integer execute cluster
   Directed and random issue to both units, scoreboard by ROB tag,
   concurrent assertions on every CDB broadcast */
`timescale 1ns/1ns

module exec_cluster_tb import exec_pkg::*; ();

	localparam int N_ARITH    = 40;
	localparam int N_CONT     = 30;
	localparam int N_INSTR    = N_ARITH + 15 + 21 + 12 + 2 * N_CONT;
	localparam int MAX_CYCLES = N_INSTR * (XLEN + 2) + 200; // Worst shift latency each

	logic                 clk;
	logic                 arst_n;
	logic                 add_valid;
	logic                 add_ready;
	alu_op_e              add_op;
	branch_e              add_branch;
	logic [XLEN-1:0]      add_rs1;
	logic [XLEN-1:0]      add_rs2;
	logic [ROB_TAG_W-1:0] add_tag;
	logic                 add_load;
	logic                 sh_valid;
	logic                 sh_ready;
	alu_op_e              sh_op;
	logic [XLEN-1:0]      sh_rs1;
	logic [XLEN-1:0]      sh_rs2;
	logic [ROB_TAG_W-1:0] sh_tag;
	logic                 cdb_valid;
	logic [XLEN-1:0]      cdb_result;
	logic [ROB_TAG_W-1:0] cdb_tag;
	logic                 cdb_taken;
	logic                 cdb_load_step1;

	// Scoreboard, tags 0-7 for the add unit and 8-15 for the shift unit
	logic [XLEN-1:0] exp_result [2**ROB_TAG_W];
	logic            exp_taken [2**ROB_TAG_W];
	logic            exp_load [2**ROB_TAG_W];
	int              exp_lat [2**ROB_TAG_W]; // Zero when contended
	int              issue_cyc [2**ROB_TAG_W];
	bit              outstanding [2**ROB_TAG_W];
	bit              add_busy;
	bit              sh_busy;
	logic            rst_win;
	int              cyc;
	int              seen;
	int              issued;
	int              errors;
	int              tests;
	int              add_next;
	int              sh_next;
	int              seed;
	alu_op_e         arith_ops [7] = '{OP_ADD, OP_SUB, OP_XOR, OP_OR, OP_AND, OP_SLT, OP_SLTU};
	alu_op_e         shift_ops [3] = '{OP_SLL, OP_SRL, OP_SRA};
	logic [XLEN-1:0] edge_a [5] = '{32'd5, 32'h7fff_ffff, 32'h8000_0000, 32'h8000_0000, 32'h0};
	logic [XLEN-1:0] edge_b [5] = '{32'd5, 32'h8000_0000, 32'h7fff_ffff, 32'h1, 32'hffff_ffff};

	exec_cluster dut0 (.*);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	function automatic logic [XLEN-1:0] next_rand();
		return $random(seed);
	endfunction

	function automatic void log_error(string msg);
		$display("%s", msg);
		errors++;
	endfunction

	// RV32 reference results
	function automatic logic [XLEN-1:0] expect_alu(alu_op_e op, logic [XLEN-1:0] a,
			logic [XLEN-1:0] b);
		case (op)
			OP_ADD:  return a + b;
			OP_SUB:  return a - b;
			OP_SLT:  return {{(XLEN - 1){1'b0}}, $signed(a) < $signed(b)};
			OP_SLTU: return {{(XLEN - 1){1'b0}}, a < b};
			OP_XOR:  return a ^ b;
			OP_OR:   return a | b;
			OP_AND:  return a & b;
			OP_SLL:  return a << b[4:0];
			OP_SRL:  return a >> b[4:0];
			OP_SRA:  return $signed(a) >>> b[4:0];
			default: return '0;
		endcase
	endfunction

	function automatic logic expect_taken(branch_e br, logic [XLEN-1:0] a, logic [XLEN-1:0] b);
		case (br)
			BR_BEQ:  return a == b;
			BR_BNE:  return a != b;
			BR_BLT:  return $signed(a) < $signed(b);
			BR_BGE:  return $signed(a) >= $signed(b);
			BR_BLTU: return a < b;
			BR_BGEU: return a >= b;
			default: return 1'b0;
		endcase
	endfunction

	task automatic issue_add(alu_op_e op, branch_e br, logic [XLEN-1:0] a, logic [XLEN-1:0] b,
			logic ld, bit timed);
		logic [ROB_TAG_W-1:0] t;
		while (!add_ready) @(negedge clk);
		t = ROB_TAG_W'(add_next);
		add_next = (add_next + 1) % 8;
		exp_result[t] = expect_alu(op, a, b);
		exp_taken[t] = expect_taken(br, a, b);
		exp_load[t] = ld;
		exp_lat[t] = timed ? 2 : 0;
		issue_cyc[t] = cyc;
		add_op = op;
		add_branch = br;
		add_rs1 = a;
		add_rs2 = b;
		add_tag = t;
		add_load = ld;
		add_valid = 1'b1;
		@(negedge clk);
		add_valid = 1'b0;
		issued++;
	endtask

	task automatic start_shift(alu_op_e op, logic [XLEN-1:0] a, logic [XLEN-1:0] b, bit timed);
		logic [ROB_TAG_W-1:0] t;
		while (!sh_ready) @(negedge clk);
		t = ROB_TAG_W'(8 + sh_next);
		sh_next = (sh_next + 1) % 8;
		exp_result[t] = expect_alu(op, a, b);
		exp_taken[t] = 1'b0;
		exp_load[t] = 1'b0;
		exp_lat[t] = timed ? int'(b[4:0]) + 2 : 0;
		issue_cyc[t] = cyc;
		sh_op = op;
		sh_rs1 = a;
		sh_rs2 = b;
		sh_tag = t;
		sh_valid = 1'b1;
		@(negedge clk);
		sh_valid = 1'b0;
		issued++;
	endtask

	// Wait until both units are idle and every result is broadcast
	task automatic end_test(string name);
		while (add_busy || sh_busy || !add_ready || !sh_ready) @(negedge clk);
		tests++;
		$display("test %s finished, %0d errors so far", name, errors);
	endtask

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cdb_valid) begin
			outstanding[cdb_tag] <= 1'b0;
			seen <= seen + 1;
			if (cdb_tag[3]) sh_busy <= 1'b0;
			else add_busy <= 1'b0;
		end
		if (add_valid && add_ready) begin // Set after the clear, same edge may reissue
			outstanding[add_tag] <= 1'b1;
			add_busy <= 1'b1;
		end
		if (sh_valid && sh_ready) begin
			outstanding[sh_tag] <= 1'b1;
			sh_busy <= 1'b1;
		end
	end

	always @(posedge clk) begin
		if (cyc >= MAX_CYCLES) begin
			$display("Simulation timed out after %0d cycles", cyc);
			$display("Verification failed");
			$finish;
		end
	end

	// Checks at the falling edge, where DUT outputs and scoreboard are settled
	a_reset: assert property (@(negedge clk) rst_win |-> !cdb_valid && add_ready && sh_ready)
		else log_error("CDB valid or a unit not ready during or just after reset");
	a_known_tag: assert property (@(negedge clk) disable iff (!arst_n)
		cdb_valid |-> outstanding[cdb_tag])
		else log_error($sformatf("CDB broadcast tag %h which is not in flight", cdb_tag));
	a_result: assert property (@(negedge clk) disable iff (!arst_n)
		cdb_valid |-> cdb_result == exp_result[cdb_tag])
		else log_error($sformatf("mismatch cdb_result tag %h: got %h expected %h",
			cdb_tag, cdb_result, exp_result[cdb_tag]));
	a_taken: assert property (@(negedge clk) disable iff (!arst_n)
		cdb_valid |-> cdb_taken == exp_taken[cdb_tag])
		else log_error($sformatf("mismatch cdb_taken tag %h: got %h expected %h",
			cdb_tag, cdb_taken, exp_taken[cdb_tag]));
	a_load: assert property (@(negedge clk) disable iff (!arst_n)
		cdb_valid |-> cdb_load_step1 == exp_load[cdb_tag])
		else log_error($sformatf("mismatch cdb_load_step1 tag %h: got %h expected %h",
			cdb_tag, cdb_load_step1, exp_load[cdb_tag]));
	a_latency: assert property (@(negedge clk) disable iff (!arst_n)
		cdb_valid && exp_lat[cdb_tag] != 0 |-> cyc - issue_cyc[cdb_tag] == exp_lat[cdb_tag])
		else log_error($sformatf("tag %h reached the CDB after %0d cycles instead of %0d",
			cdb_tag, cyc - issue_cyc[cdb_tag], exp_lat[cdb_tag]));
	a_add_ready: assert property (@(negedge clk) disable iff (!arst_n)
		add_ready |-> !add_busy || (cdb_valid && !cdb_tag[3]))
		else log_error("add unit became ready before its result was broadcast");
	a_sh_ready: assert property (@(negedge clk) disable iff (!arst_n)
		sh_ready |-> !sh_busy || (cdb_valid && cdb_tag[3]))
		else log_error("shift unit became ready before its result was broadcast");

	initial begin
		logic [XLEN-1:0] r;
		seed = 32'h55c6_af64;
		arst_n = 1'b0;
		rst_win = 1'b1;
		add_valid = 1'b0;
		add_op = OP_ADD;
		add_branch = BR_NONE;
		add_rs1 = '0;
		add_rs2 = '0;
		add_tag = '0;
		add_load = 1'b0;
		sh_valid = 1'b0;
		sh_op = OP_SLL;
		sh_rs1 = '0;
		sh_rs2 = '0;
		sh_tag = '0;
		repeat (3) @(negedge clk);
		arst_n = 1'b1;
		repeat (2) @(posedge clk);
		rst_win = 1'b0;
		@(negedge clk);
		end_test("reset");

		for (int i = 0; i < N_ARITH; i++)
			issue_add(arith_ops[next_rand() % 7], BR_NONE, next_rand(), next_rand(),
				next_rand() % 2 != 0, 1'b1);
		for (int j = 0; j < 5; j++) begin // Equal, sign boundary and overflow operands
			issue_add(OP_SLT, BR_NONE, edge_a[j], edge_b[j], 1'b0, 1'b1);
			issue_add(OP_SLTU, BR_NONE, edge_a[j], edge_b[j], 1'b1, 1'b1);
			issue_add(OP_SUB, BR_NONE, edge_a[j], edge_b[j], 1'b0, 1'b1);
		end
		end_test("arith");

		for (int b = 0; b < 7; b++) begin
			r = next_rand();
			issue_add(OP_SUB, branch_e'(b), r, r, 1'b0, 1'b1);
			issue_add(OP_SUB, branch_e'(b), next_rand(), next_rand(), 1'b1, 1'b1);
			issue_add(OP_SUB, branch_e'(b), 32'h8000_0000, 32'h7fff_ffff, 1'b0, 1'b1);
		end
		end_test("branch");

		for (int k = 0; k < 3; k++) begin
			start_shift(shift_ops[k], next_rand(), next_rand() & ~32'h1f, 1'b1);
			start_shift(shift_ops[k], next_rand() | 32'h8000_0000, next_rand() | 32'h1f, 1'b1);
			start_shift(shift_ops[k], next_rand(), next_rand(), 1'b1);
			start_shift(shift_ops[k], next_rand(), next_rand(), 1'b1);
		end
		end_test("shift");

		fork
			for (int i = 0; i < N_CONT; i++)
				issue_add(arith_ops[next_rand() % 7], BR_NONE, next_rand(), next_rand(),
					next_rand() % 2 != 0, 1'b0);
			for (int i = 0; i < N_CONT; i++) // Short counts for frequent collisions
				start_shift(shift_ops[next_rand() % 3], next_rand(), next_rand() & 32'h7, 1'b0);
		join
		end_test("contention");

		if (seen != issued)
			log_error($sformatf("%0d results broadcast for %0d issued instructions", seen, issued));
		$display("%0d tests, %0d results checked, %0d errors", tests, seen, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

// ==== exec_cluster.f ====
logic/exec_pkg.sv
logic/ripple_adder.sv
logic/add_unit.sv
logic/shift_unit.sv
logic/cdb_arbiter.sv
logic/exec_cluster.sv
test/exec_cluster_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the execute cluster testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f exec_cluster.f \
	--top-module exec_cluster_tb -Mdir obj_dir
./obj_dir/Vexec_cluster_tb | tee sim.log
grep -q "^Verification passed$" sim.log
